// ==== rtl/audio_pkg.sv ====
package audio_pkg;

  typedef logic signed [15:0] sample_t;

  // wide enough for N_TAPS products of two full-scale samples
  typedef logic signed [39:0] acc_t;

  typedef struct packed {
    logic    valid;
    sample_t data;
  } sample_stream_t;

  // pole of the dc blocker, 1 - 2^-5
  localparam int DC_POLE_SHIFT = 5;

  localparam sample_t SAMPLE_MAX = 16'sh7fff;
  localparam sample_t SAMPLE_MIN = -16'sh8000;

  // clamp a wide result back into 16 bits
  function automatic sample_t sat_sample(acc_t v);
    if (v > acc_t'(SAMPLE_MAX)) begin
      return SAMPLE_MAX;
    end
    if (v < acc_t'(SAMPLE_MIN)) begin
      return SAMPLE_MIN;
    end
    return sample_t'(v);
  endfunction

endpackage

// ==== rtl/bus_pkg.sv ====
package bus_pkg;

  // impulse memory address width, 64 words max
  localparam int IR_ADDR_W = 6;

  // wishbone classic, master to slave
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [IR_ADDR_W-1:0] adr;
    audio_pkg::sample_t   dat_w;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic               ack;
    audio_pkg::sample_t dat_r;
  } wb_rsp_t;

endpackage

// ==== rtl/i2s_mic_rx.sv ====
module i2s_mic_rx #(
  parameter int BCLK_DIV = 2
) (
  input  logic                       audio_clk,
  input  logic                       rst_n,
  input  logic                       mic_data,
  output logic                       mic_bclk,
  output logic                       mic_lrcl,
  output audio_pkg::sample_stream_t  raw
);
  import audio_pkg::*;

  localparam int DIV_W = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;
  logic [5:0]       slot;     // bit slot within the 64-slot frame
  logic             bclk_toggle;
  logic             bclk_rise;
  logic             raw_valid;
  sample_t          shift_q;

  assign bclk_toggle = (div_cnt == DIV_W'(BCLK_DIV - 1));
  assign bclk_rise   = bclk_toggle && !mic_bclk;

  // word clock low for slots 0..31
  assign mic_lrcl = slot[5];

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt  <= '0;
      mic_bclk <= 1'b0;
      slot     <= '0;
    end else if (bclk_toggle) begin
      div_cnt  <= '0;
      mic_bclk <= !mic_bclk;
      if (mic_bclk) slot <= slot + 6'd1;  // next slot starts on the falling edge
    end else begin
      div_cnt <= div_cnt + DIV_W'(1);
    end
  end

  // slot 0 is the one-bit delay, data in 1..16 msb first
  always_ff @(posedge audio_clk) begin
    if (bclk_rise && slot >= 6'd1 && slot <= 6'd16) begin
      shift_q <= {shift_q[14:0], mic_data};
    end
  end

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      raw_valid <= 1'b0;
    end else begin
      raw_valid <= bclk_rise && (slot == 6'd16);  // lsb captured this edge
    end
  end

  assign raw = '{valid: raw_valid, data: shift_q};

endmodule

// ==== rtl/dc_blocker.sv ====
module dc_blocker (
  input  logic                       audio_clk,
  input  logic                       rst_n,
  input  audio_pkg::sample_stream_t  raw,
  output audio_pkg::sample_stream_t  dry
);
  import audio_pkg::*;

  sample_t x_prev;
  sample_t y_prev;   // also the output word
  logic    dry_valid;
  acc_t    y_full;

  // y = x - x' + y' - y'/32
  always_comb begin
    y_full = acc_t'(raw.data) - acc_t'(x_prev) + acc_t'(y_prev)
           - acc_t'(y_prev >>> DC_POLE_SHIFT);
  end

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      x_prev    <= '0;
      y_prev    <= '0;
      dry_valid <= 1'b0;
    end else begin
      dry_valid <= raw.valid;
      if (raw.valid) begin
        x_prev <= raw.data;
        y_prev <= sat_sample(y_full);
      end
    end
  end

  assign dry = '{valid: dry_valid, data: y_prev};

endmodule

// ==== rtl/ir_recorder.sv ====
module ir_recorder #(
  parameter int N_TAPS = 16
) (
  input  logic                       audio_clk,
  input  logic                       rst_n,
  input  logic                       record,
  input  logic [7:0]                 delay_samples,
  input  audio_pkg::sample_stream_t  dry,
  output bus_pkg::wb_req_t           wb_req,
  input  bus_pkg::wb_rsp_t           wb_rsp,
  output logic                       ir_ready
);
  import audio_pkg::*;
  import bus_pkg::*;

  localparam int IDX_W = (N_TAPS > 1) ? $clog2(N_TAPS) : 1;

  typedef enum logic [1:0] {S_IDLE, S_DELAY, S_CAPTURE, S_WRITE} rec_state_t;

  rec_state_t       state;
  logic             record_q;
  logic             rec_rise;
  logic             arm_pend;   // request seen mid-write
  logic             arm_now;
  logic [7:0]       delay_cnt;
  logic [IDX_W-1:0] tap_idx;
  logic             wr_busy;
  sample_t          last_dry;

  assign rec_rise = record && !record_q;
  // never abandon a bus cycle in flight
  assign arm_now  = (arm_pend || rec_rise) && (state != S_WRITE);

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      record_q  <= 1'b0;
      arm_pend  <= 1'b0;
      delay_cnt <= '0;
      tap_idx   <= '0;
      wr_busy   <= 1'b0;
      ir_ready  <= 1'b0;
    end else begin
      record_q <= record;
      arm_pend <= (arm_pend || rec_rise) && (state == S_WRITE);
      if (arm_now) begin
        ir_ready  <= 1'b0;
        tap_idx   <= '0;
        delay_cnt <= delay_samples;
        state     <= (delay_samples == 8'd0) ? S_CAPTURE : S_DELAY;
      end else begin
        case (state)
          S_DELAY: if (dry.valid) begin
            delay_cnt <= delay_cnt - 8'd1;
            if (delay_cnt == 8'd1) state <= S_CAPTURE;
          end
          S_CAPTURE: if (dry.valid) begin
            wr_busy <= 1'b1;
            state   <= S_WRITE;
          end
          S_WRITE: if (wb_rsp.ack) begin
            wr_busy <= 1'b0;
            if (tap_idx == IDX_W'(N_TAPS - 1)) begin
              ir_ready <= 1'b1;
              state    <= S_IDLE;
            end else begin
              tap_idx <= tap_idx + IDX_W'(1);
              state   <= S_CAPTURE;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (dry.valid) last_dry <= dry.data;
  end

  assign wb_req = '{cyc: wr_busy, stb: wr_busy, we: 1'b1,
                    adr: IR_ADDR_W'(tap_idx), dat_w: last_dry};

  // a write must win arbitration and finish within one sample period
  a_write_before_next_sample: assert property (
    @(posedge audio_clk) disable iff (!rst_n) (state == S_WRITE) |-> !dry.valid
  ) else $error("ir_recorder: dry sample arrived during a pending write");

endmodule

// ==== rtl/ir_convolver.sv ====
module ir_convolver #(
  parameter int N_TAPS    = 16,
  parameter int WET_SHIFT = 15
) (
  input  logic                       audio_clk,
  input  logic                       rst_n,
  input  logic                       ir_ready,
  input  audio_pkg::sample_stream_t  dry,
  output bus_pkg::wb_req_t           wb_req,
  input  bus_pkg::wb_rsp_t           wb_rsp,
  output audio_pkg::sample_stream_t  wet
);
  import audio_pkg::*;
  import bus_pkg::*;

  localparam int IDX_W = (N_TAPS > 1) ? $clog2(N_TAPS) : 1;

  sample_t          hist [N_TAPS];  // newest at 0
  logic             rdy_q;
  logic             ir_rise;
  logic             start;
  logic             busy;
  logic             tap_ack;
  logic             last_ack;
  logic [IDX_W-1:0] k;              // current tap
  acc_t             acc;
  acc_t             acc_next;
  logic             wet_valid;
  sample_t          wet_data;

  assign ir_rise  = ir_ready && !rdy_q;
  assign start    = dry.valid && ir_ready;
  assign tap_ack  = busy && wb_rsp.ack;
  assign last_ack = tap_ack && (k == IDX_W'(N_TAPS - 1));

  // h[k] * x[n-k]
  assign acc_next = acc + acc_t'(wb_rsp.dat_r) * acc_t'(hist[k]);

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_q     <= 1'b0;
      busy      <= 1'b0;
      k         <= '0;
      wet_valid <= 1'b0;
    end else begin
      rdy_q     <= ir_ready;
      wet_valid <= last_ack && ir_ready;  // drop the result if a new recording began
      if (start) begin
        busy <= 1'b1;
        k    <= '0;
      end else if (tap_ack) begin
        if (last_ack) busy <= 1'b0;
        else k <= k + IDX_W'(1);  // stb stays up, next address follows
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (start) begin
      acc <= '0;
    end else if (tap_ack) begin
      acc <= acc_next;
    end
    if (last_ack) wet_data <= sat_sample(acc_next >>> WET_SHIFT);
    if (ir_rise) begin
      // fresh impulse, forget old history
      for (int i = 0; i < N_TAPS; i++) begin
        hist[i] <= '0;
      end
    end else if (start) begin
      hist[0] <= dry.data;
      for (int i = 1; i < N_TAPS; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  assign wb_req = '{cyc: busy, stb: busy, we: 1'b0,
                    adr: IR_ADDR_W'(k), dat_w: '0};

  assign wet = '{valid: wet_valid, data: wet_data};

  // all N_TAPS fetches, arbitration included, fit in one sample period
  a_fetch_fits_period: assert property (
    @(posedge audio_clk) disable iff (!rst_n) dry.valid |-> !busy
  ) else $error("ir_convolver: tap fetch still running at next dry sample");

endmodule

// ==== rtl/wb_arbiter.sv ====
module wb_arbiter (
  input  logic              audio_clk,
  input  logic              rst_n,
  input  bus_pkg::wb_req_t  rec_req,
  output bus_pkg::wb_rsp_t  rec_rsp,
  input  bus_pkg::wb_req_t  conv_req,
  output bus_pkg::wb_rsp_t  conv_rsp,
  output bus_pkg::wb_req_t  mem_req,
  input  bus_pkg::wb_rsp_t  mem_rsp
);
  import bus_pkg::*;

  logic    gnt_conv;   // 0: recorder owns the bus
  wb_req_t owner_req;

  assign owner_req = gnt_conv ? conv_req : rec_req;

  // re-decide only once the owner lets go of cyc, recorder first
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_conv <= 1'b0;
    end else if (!owner_req.cyc) begin
      gnt_conv <= !rec_req.cyc && conv_req.cyc;
    end
  end

  assign mem_req = owner_req;

  always_comb begin
    rec_rsp  = '0;
    conv_rsp = '0;
    if (gnt_conv) conv_rsp = mem_rsp;
    else          rec_rsp  = mem_rsp;
  end

  // an ack must land on the master whose strobe caused it
  a_rec_ack_with_stb: assert property (
    @(posedge audio_clk) disable iff (!rst_n) rec_rsp.ack |-> rec_req.stb
  ) else $error("wb_arbiter: recorder acked without stb");

  a_conv_ack_with_stb: assert property (
    @(posedge audio_clk) disable iff (!rst_n) conv_rsp.ack |-> conv_req.stb
  ) else $error("wb_arbiter: convolver acked without stb");

endmodule

// ==== rtl/ir_memory.sv ====
module ir_memory #(
  parameter int N_TAPS = 16
) (
  input  logic              audio_clk,
  input  logic              rst_n,
  input  bus_pkg::wb_req_t  wb_req,
  output bus_pkg::wb_rsp_t  wb_rsp
);
  import audio_pkg::*;

  localparam int IDX_W = (N_TAPS > 1) ? $clog2(N_TAPS) : 1;

  sample_t          mem [N_TAPS];
  sample_t          rd_data;
  logic             ack;
  logic             access;
  logic [IDX_W-1:0] idx;

  assign access = wb_req.cyc && wb_req.stb && !ack;  // ack cycle is not a new request
  assign idx    = wb_req.adr[IDX_W-1:0];

  always_ff @(posedge audio_clk) begin
    if (access && wb_req.we) mem[idx] <= wb_req.dat_w;
    rd_data <= mem[idx];
  end

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) ack <= 1'b0;
    else        ack <= access;
  end

  assign wb_rsp = '{ack: ack, dat_r: rd_data};

endmodule

// ==== rtl/reverb_top.sv ====
module reverb_top #(
  parameter int N_TAPS    = 16,
  parameter int WET_SHIFT = 15,
  parameter int BCLK_DIV  = 2
) (
  input  logic                       audio_clk,
  input  logic                       rst_n,
  input  logic                       mic_data,
  output logic                       mic_bclk,
  output logic                       mic_lrcl,
  input  logic                       record,
  input  logic [7:0]                 delay_samples,
  output audio_pkg::sample_stream_t  dry,
  output audio_pkg::sample_stream_t  wet,
  output logic                       ir_ready
);
  import audio_pkg::*;
  import bus_pkg::*;

  sample_stream_t raw;
  wb_req_t        rec_req;
  wb_req_t        conv_req;
  wb_req_t        mem_req;
  wb_rsp_t        rec_rsp;
  wb_rsp_t        conv_rsp;
  wb_rsp_t        mem_rsp;

  i2s_mic_rx #(.BCLK_DIV(BCLK_DIV)) u_i2s_mic_rx (
    .audio_clk, .rst_n, .mic_data, .mic_bclk, .mic_lrcl, .raw
  );

  dc_blocker u_dc_blocker (
    .audio_clk, .rst_n, .raw, .dry
  );

  // writes the impulse
  ir_recorder #(.N_TAPS(N_TAPS)) u_ir_recorder (
    .audio_clk, .rst_n, .record, .delay_samples, .dry,
    .wb_req(rec_req), .wb_rsp(rec_rsp), .ir_ready
  );

  // reads it back every sample
  ir_convolver #(.N_TAPS(N_TAPS), .WET_SHIFT(WET_SHIFT)) u_ir_convolver (
    .audio_clk, .rst_n, .ir_ready, .dry,
    .wb_req(conv_req), .wb_rsp(conv_rsp), .wet
  );

  wb_arbiter u_wb_arbiter (
    .audio_clk, .rst_n, .rec_req, .rec_rsp, .conv_req, .conv_rsp,
    .mem_req, .mem_rsp
  );

  ir_memory #(.N_TAPS(N_TAPS)) u_ir_memory (
    .audio_clk, .rst_n, .wb_req(mem_req), .wb_rsp(mem_rsp)
  );

endmodule

// ==== bench/reverb_checker.sv ====
module reverb_checker #(
  parameter int N_TAPS    = 16,
  parameter int WET_SHIFT = 15,
  parameter int BCLK_DIV  = 2
) (
  input  logic                       audio_clk,
  input  logic                       rst_n,
  input  logic                       mic_bclk,
  input  logic                       mic_lrcl,
  input  logic                       record,
  input  logic [7:0]                 delay_samples,
  input  audio_pkg::sample_stream_t  dry,
  input  audio_pkg::sample_stream_t  wet,
  input  logic                       ir_ready,
  input  audio_pkg::sample_t         sent_sample,
  input  int                         sent_cnt,
  output int                         errors,
  output int                         checks,
  output int                         pending
);
  import audio_pkg::*;

  localparam longint PERIOD = longint'(128 * BCLK_DIV);

  sample_t mic_q [$];      // samples sent by the mic model, oldest first
  sample_t exp_wet [$];
  sample_t hist [N_TAPS];  // newest dry sample at 0
  sample_t shadow [N_TAPS];
  sample_t fresh [N_TAPS]; // impulse being recorded
  sample_t exp_s;
  sample_t mic_s;
  sample_t dry_exp;        // model output for the current dry sample
  longint  x_prev;
  longint  y_prev;
  longint  cycle;
  longint  last_dry;
  int      seen_cnt;
  int      skip;
  int      taps_got;
  int      err_n;
  int      chk_n;
  logic    record_q;
  logic    ready_q;
  logic    recorded;
  logic    bclk_q;
  logic    lrcl_exp;
  logic [5:0] slot_c;      // bit slot within the 64-slot frame

  assign errors = err_n;
  assign checks = chk_n;

  function automatic sample_t sat16(longint v);
    if (v > 64'sd32767) return 16'sh7fff;
    if (v < -64'sd32768) return 16'sh8000;
    return sample_t'(v);
  endfunction

  // high-pass rule, y = x - x' + y' - y'/2^shift
  function automatic sample_t dc_ref(longint x, longint xp, longint yp);
    return sat16(x - xp + yp - (yp >>> DC_POLE_SHIFT));
  endfunction

  function automatic sample_t wet_ref();
    longint sum;
    sum = 0;
    for (int k = 0; k < N_TAPS; k++) begin
      sum += longint'(shadow[k]) * longint'(hist[k]);
    end
    return sat16(sum >>> WET_SHIFT);
  endfunction

  task automatic fail_value(input string what, input longint expv, input longint gotv);
    $display("Mismatch at time %0t: %s expected %0d got %0d", $time, what, expv, gotv);
    err_n++;
  endtask

  task automatic fail_other(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    err_n++;
  endtask

  always @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      mic_q.delete();
      exp_wet.delete();
      x_prev   = 0;
      y_prev   = 0;
      cycle    = 0;
      last_dry = -1;
      seen_cnt = sent_cnt;
      skip     = 0;
      taps_got = 0;
      record_q = 1'b0;
      ready_q  = 1'b0;
      recorded = 1'b0;
      bclk_q   = 1'b0;
      slot_c   = '0;
      pending  <= 0;
    end else begin
      cycle++;
      if (sent_cnt != seen_cnt) begin
        mic_q.push_back(sent_sample);
        seen_cnt = sent_cnt;
      end

      // word clock low for the first 32 bit clocks of each frame
      if (bclk_q && !mic_bclk) slot_c = slot_c + 6'd1;
      lrcl_exp = (slot_c >= 6'd32);
      if (mic_lrcl !== lrcl_exp) fail_value("word clock", lrcl_exp, mic_lrcl);
      bclk_q = mic_bclk;

      // wet is handled before a falling ir_ready drops the expectation
      if (wet.valid) begin
        if (exp_wet.size() == 0) begin
          fail_other("wet sample produced with no dry sample to answer");
        end else begin
          exp_s = exp_wet.pop_front();
          chk_n++;
          if (wet.data !== exp_s) fail_value("wet sample", exp_s, wet.data);
        end
      end
      if (ready_q && !ir_ready) exp_wet.delete();  // fetch in flight is dropped
      if (ir_ready && !recorded) fail_other("ir_ready is high before any recording");

      if (ir_ready && !ready_q) begin
        if (taps_got != N_TAPS) fail_other("ir_ready rose before the impulse was captured");
        shadow = fresh;
        for (int i = 0; i < N_TAPS; i++) hist[i] = '0;
      end

      if (dry.valid) begin
        if (last_dry >= 0 && cycle - last_dry != PERIOD) begin
          fail_value("dry sample period", PERIOD, cycle - last_dry);
        end
        last_dry = cycle;
        if (mic_q.size() == 0) begin
          fail_other("dry sample with no microphone sample behind it");
          dry_exp = '0;
        end else begin
          mic_s   = mic_q.pop_front();
          dry_exp = dc_ref(longint'(mic_s), x_prev, y_prev);
          chk_n++;
          if (dry.data !== dry_exp) fail_value("dry sample", dry_exp, dry.data);
          x_prev = longint'(mic_s);
          y_prev = longint'(dry_exp);
        end
      end

      // impulse capture, a request on this edge hides this dry sample
      if (record && !record_q) begin
        recorded = 1'b1;
        skip     = int'(delay_samples);
        taps_got = 0;
      end else if (dry.valid && taps_got < N_TAPS) begin
        if (skip > 0) begin
          skip--;
        end else begin
          fresh[taps_got] = dry_exp;
          taps_got++;
        end
      end

      if (dry.valid && ir_ready) begin
        if (ready_q) begin
          for (int i = N_TAPS - 1; i > 0; i--) hist[i] = hist[i-1];
          hist[0] = dry_exp;
        end
        exp_wet.push_back(wet_ref());
      end

      record_q = record;
      ready_q  = ir_ready;
      pending  <= exp_wet.size();
    end
  end

endmodule

// ==== bench/tb_reverb.sv ====
module tb_reverb;
  import audio_pkg::*;

  localparam int N_TAPS    = 16;
  localparam int WET_SHIFT = 15;
  localparam int BCLK_DIV  = 2;
  localparam int PERIOD    = 128 * BCLK_DIV;

  logic           audio_clk;
  logic           rst_n;
  logic           mic_data;
  logic           mic_bclk;
  logic           mic_lrcl;
  logic           record;
  logic [7:0]     delay_samples;
  logic           ir_ready;
  sample_stream_t dry;
  sample_stream_t wet;

  sample_t        sent_sample;
  int             sent_cnt;
  logic [31:0]    rng;
  sample_t        shreg;    // bits still to send this frame
  logic [5:0]     slot_m = 6'd0;
  bit             timed_out;
  int             errors;
  int             checks;
  int             pending;

  reverb_top #(.N_TAPS(N_TAPS), .WET_SHIFT(WET_SHIFT), .BCLK_DIV(BCLK_DIV)) u_reverb_top (
    .audio_clk, .rst_n, .mic_data, .mic_bclk, .mic_lrcl, .record, .delay_samples,
    .dry, .wet, .ir_ready
  );

  reverb_checker #(.N_TAPS(N_TAPS), .WET_SHIFT(WET_SHIFT), .BCLK_DIV(BCLK_DIV)) u_checker (
    .audio_clk, .rst_n, .mic_bclk, .mic_lrcl, .record, .delay_samples, .dry, .wet,
    .ir_ready, .sent_sample, .sent_cnt, .errors, .checks, .pending
  );

  always #2 audio_clk = !audio_clk;

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // mic model, slot counter follows the falling bit clock like the receiver
  always @(negedge mic_bclk) begin
    if (rst_n) begin
      slot_m = slot_m + 6'd1;
      if (slot_m == 6'd1) begin
        rng   = xorshift32(rng);
        shreg = sample_t'(rng[15:0]) >>> 3;  // keep headroom in the wet sum
        sent_sample <= shreg;
        sent_cnt    <= sent_cnt + 1;
      end
      if (slot_m >= 6'd1 && slot_m <= 6'd16) begin
        mic_data <= shreg[15];
        shreg = shreg << 1;
      end else begin
        mic_data <= 1'b0;
      end
    end
  end

  task automatic wait_dry(input int n);
    int seen;
    int cyc;
    seen = 0;
    cyc  = 0;
    while (!timed_out && seen < n) begin
      @(posedge audio_clk);
      cyc++;
      if (dry.valid) seen++;
      if (cyc > (n + 2) * PERIOD) begin
        $display("timeout: only %0d of %0d dry samples arrived", seen, n);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic wait_ready(input logic level, input int limit);
    int cyc;
    cyc = 0;
    while (!timed_out && ir_ready !== level) begin
      @(posedge audio_clk);
      cyc++;
      if (cyc > limit) begin
        $display("timeout: ir_ready did not go to %0b", level);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic wait_wet();
    int cyc;
    cyc = 0;
    while (!timed_out && !wet.valid) begin
      @(posedge audio_clk);
      cyc++;
      if (cyc > 2 * PERIOD) begin
        $display("timeout: no wet sample followed the last dry sample");
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic request_record(input logic [7:0] d);
    @(posedge audio_clk);
    record        <= 1'b1;
    delay_samples <= d;
    repeat (2) @(posedge audio_clk);
    record <= 1'b0;
  endtask

  task automatic finish_run();
    if (pending != 0) $display("expected wet samples never arrived");
    $display("checks: %0d, errors: %0d, wet pending: %0d, timeouts: %0d",
             checks, errors, pending, timed_out);
    if (!timed_out && errors == 0 && pending == 0 && checks > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  initial begin
    audio_clk     = 1'b0;
    rst_n         = 1'b0;
    mic_data      = 1'b0;
    record        = 1'b0;
    delay_samples = 8'd0;
    sent_sample   = '0;
    sent_cnt      = 0;
    rng           = 32'd66481;
    shreg         = '0;
    timed_out     = 1'b0;
    repeat (5) @(posedge audio_clk);
    rst_n <= 1'b1;

    wait_dry(20);                     // dry path alone, no wet expected
    request_record(8'd3);
    wait_ready(1'b1, (3 + N_TAPS + 4) * PERIOD);
    wait_dry(40);

    request_record(8'd9);             // new impulse replaces the first
    wait_ready(1'b0, 8);
    wait_ready(1'b1, (9 + N_TAPS + 4) * PERIOD);
    wait_dry(40);

    wait_dry(1);
    wait_wet();
    @(posedge audio_clk);
    finish_run();
  end

endmodule

// ==== sim.f ====
rtl/audio_pkg.sv
rtl/bus_pkg.sv
rtl/i2s_mic_rx.sv
rtl/dc_blocker.sv
rtl/ir_recorder.sv
rtl/ir_convolver.sv
rtl/wb_arbiter.sv
rtl/ir_memory.sv
rtl/reverb_top.sv
bench/reverb_checker.sv
bench/tb_reverb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the reverb testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_reverb -Mdir obj_dir -f sim.f

status=0
./obj_dir/Vtb_reverb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "^ALL CHECKS PASSED$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
